/* rtl/fade_pkg.sv */
`default_nettype none

package fade_pkg;

  // horizontal raster, in clocks
  localparam int h_visible     = 16;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse  = 3;
  localparam int h_back_porch  = 3;
  localparam int h_whole_line  = 24;

  // vertical raster, in lines
  localparam int v_visible     = 12;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse  = 2;
  localparam int v_back_porch  = 1;
  localparam int v_whole_frame = 16;

  // one word per visible pixel
  localparam int fb_depth = 192;

  // fade schedule
  localparam int initial_age = 4;
  localparam int dim_age     = 2;

  localparam int queue_depth_log2 = 2;

  typedef logic [3:0]  x_t;
  typedef logic [3:0]  y_t;
  typedef logic [4:0]  h_count_t;
  typedef logic [3:0]  v_count_t;
  typedef logic [7:0]  fb_addr_t;
  typedef logic [3:0]  channel_t;
  // red, green, blue from msb down
  typedef logic [11:0] pixel_t;
  typedef logic [3:0]  age_t;
  // age in the top nibble, pixel below
  typedef logic [15:0] fb_word_t;

endpackage

`default_nettype wire

/* rtl/scan_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_timing (
  input  logic                clk,
  input  logic                rst,
  output logic                rd_en,
  output fade_pkg::fb_addr_t  rd_addr,
  output logic                hsync,
  output logic                vsync,
  output logic                visible
);

  fade_pkg::h_count_t h_count;
  fade_pkg::v_count_t v_count;

  logic line_end;
  logic frame_end;

  assign line_end  = (h_count == fade_pkg::h_count_t'(fade_pkg::h_whole_line - 1));
  assign frame_end = line_end &&
                     (v_count == fade_pkg::v_count_t'(fade_pkg::v_whole_frame - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      if (frame_end) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + fade_pkg::v_count_t'(1);
      end
    end else begin
      h_count <= h_count + fade_pkg::h_count_t'(1);
    end
  end

  assign visible = (h_count < fade_pkg::h_count_t'(fade_pkg::h_visible)) &&
                   (v_count < fade_pkg::v_count_t'(fade_pkg::v_visible));

  // sync pulses sit after the front porch, both active low
  assign hsync = !((h_count >= fade_pkg::h_count_t'(fade_pkg::h_visible +
                                                     fade_pkg::h_front_porch)) &&
                   (h_count <  fade_pkg::h_count_t'(fade_pkg::h_visible +
                                                     fade_pkg::h_front_porch +
                                                     fade_pkg::h_sync_pulse)));

  assign vsync = !((v_count >= fade_pkg::v_count_t'(fade_pkg::v_visible +
                                                     fade_pkg::v_front_porch)) &&
                   (v_count <  fade_pkg::v_count_t'(fade_pkg::v_visible +
                                                     fade_pkg::v_front_porch +
                                                     fade_pkg::v_sync_pulse)));

  assign rd_en = visible;

  // visible pixels come in address order, so a running count is the address
  always_ff @(posedge clk) begin
    if (rst || frame_end) begin
      rd_addr <= '0;
    end else if (visible) begin
      rd_addr <= rd_addr + fade_pkg::fb_addr_t'(1);
    end
  end

endmodule

`default_nettype wire

/* rtl/fb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_memory (
  input  logic                clk,
  input  logic                rd_en,
  input  fade_pkg::fb_addr_t  rd_addr,
  output fade_pkg::fb_word_t  rd_word,
  input  logic                wr_en,
  input  fade_pkg::fb_addr_t  wr_addr,
  input  fade_pkg::fb_word_t  wr_word
);

  fade_pkg::fb_word_t mem [fade_pkg::fb_depth];

  // screen starts out black
  initial begin
    for (int i = 0; i < fade_pkg::fb_depth; i++) begin
      mem[i] = '0;
    end
  end

  // read returns the old word when both ports hit the same address
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

  // draws outside the visible raster are dropped
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr < fade_pkg::fb_addr_t'(fade_pkg::fb_depth))) begin
      mem[wr_addr] <= wr_word;
    end
  end

endmodule

`default_nettype wire

/* rtl/fade_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fade_stage (
  input  logic                clk,
  input  logic                rst,
  input  fade_pkg::fb_word_t  rd_word,
  input  fade_pkg::fb_addr_t  addr_in,
  input  logic                hsync_in,
  input  logic                vsync_in,
  input  logic                visible_in,
  output fade_pkg::channel_t  vga_red,
  output fade_pkg::channel_t  vga_grn,
  output fade_pkg::channel_t  vga_blu,
  output logic                vga_hsync,
  output logic                vga_vsync,
  output logic                wb_push,
  output fade_pkg::fb_addr_t  wb_addr,
  output fade_pkg::fb_word_t  wb_word
);

  // first stage lines up with the memory read data
  logic               hsync_d;
  logic               vsync_d;
  logic               visible_d;
  fade_pkg::fb_addr_t addr_d;

  fade_pkg::age_t     age;
  fade_pkg::pixel_t   color;
  fade_pkg::channel_t red;
  fade_pkg::channel_t grn;
  fade_pkg::channel_t blu;
  fade_pkg::age_t     next_age;
  fade_pkg::pixel_t   next_color;
  logic               fading;

  always_ff @(posedge clk) begin
    if (rst) begin
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
      visible_d <= 1'b0;
    end else begin
      hsync_d   <= hsync_in;
      vsync_d   <= vsync_in;
      visible_d <= visible_in;
    end
  end

  always_ff @(posedge clk) begin
    addr_d <= addr_in;
  end

  assign age             = rd_word[15:12];
  assign color           = rd_word[11:0];
  assign {red, grn, blu} = color;

  // only lit pixels that still have age left get written back
  assign fading   = visible_d && (age != '0) && (color != '0);
  assign next_age = age - fade_pkg::age_t'(1);

  always_comb begin
    if (next_age == '0) begin
      next_color = '0;
    end else if (next_age == fade_pkg::age_t'(fade_pkg::dim_age)) begin
      next_color = {red >> 1, grn >> 1, blu >> 1};
    end else begin
      next_color = color;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      wb_push   <= 1'b0;
    end else begin
      vga_red   <= visible_d ? red : '0;
      vga_grn   <= visible_d ? grn : '0;
      vga_blu   <= visible_d ? blu : '0;
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
      wb_push   <= fading;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= addr_d;
    wb_word <= {next_age, next_color};
  end

endmodule

`default_nettype wire

/* rtl/fade_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fade_queue (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  fade_pkg::fb_addr_t  push_addr,
  input  fade_pkg::fb_word_t  push_word,
  input  logic                pop,
  output logic                empty,
  output fade_pkg::fb_addr_t  pop_addr,
  output fade_pkg::fb_word_t  pop_word
);

  fade_pkg::fb_addr_t addr_mem [2 ** fade_pkg::queue_depth_log2];
  fade_pkg::fb_word_t word_mem [2 ** fade_pkg::queue_depth_log2];

  logic [fade_pkg::queue_depth_log2-1:0] wr_ptr;
  logic [fade_pkg::queue_depth_log2-1:0] rd_ptr;
  logic [fade_pkg::queue_depth_log2:0]   count;

  logic full;
  logic do_push;
  logic do_pop;

  // count only reaches its top bit when every entry is taken
  assign full  = count[fade_pkg::queue_depth_log2];
  assign empty = (count == '0);

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr] <= push_addr;
      word_mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + (fade_pkg::queue_depth_log2)'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + (fade_pkg::queue_depth_log2)'(1);
      end
      if (do_push && !do_pop) begin
        count <= count + (fade_pkg::queue_depth_log2 + 1)'(1);
      end else if (do_pop && !do_push) begin
        count <= count - (fade_pkg::queue_depth_log2 + 1)'(1);
      end
    end
  end

  // head entry is shown ahead of the pop
  assign pop_addr = addr_mem[rd_ptr];
  assign pop_word = word_mem[rd_ptr];

endmodule

`default_nettype wire

/* rtl/fb_write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_write_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  logic                q_empty,
  input  fade_pkg::fb_addr_t  q_addr,
  input  fade_pkg::fb_word_t  q_word,
  output logic                q_pop,
  input  fade_pkg::x_t        gfx_x,
  input  fade_pkg::y_t        gfx_y,
  input  fade_pkg::pixel_t    gfx_color,
  input  logic                gfx_valid,
  output logic                gfx_ready,
  output logic                wr_en,
  output fade_pkg::fb_addr_t  wr_addr,
  output fade_pkg::fb_word_t  wr_word
);

  fade_pkg::fb_addr_t draw_addr;
  fade_pkg::fb_word_t draw_word;
  logic               draw;

  // fade write-backs always win, the client waits for an idle queue
  assign q_pop     = !q_empty;
  assign gfx_ready = q_empty;
  assign draw      = gfx_valid && gfx_ready;

  assign draw_addr = fade_pkg::fb_addr_t'(gfx_y) *
                     fade_pkg::fb_addr_t'(fade_pkg::h_visible) +
                     fade_pkg::fb_addr_t'(gfx_x);

  // fresh draws start at full age
  assign draw_word = {fade_pkg::age_t'(fade_pkg::initial_age), gfx_color};

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= q_pop || draw;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      wr_addr <= q_addr;
      wr_word <= q_word;
    end else begin
      wr_addr <= draw_addr;
      wr_word <= draw_word;
    end
  end

endmodule

`default_nettype wire

/* rtl/fade_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fade_display_top (
  input  logic                clk,
  input  logic                rst,
  input  fade_pkg::x_t        gfx_x,
  input  fade_pkg::y_t        gfx_y,
  input  fade_pkg::pixel_t    gfx_color,
  input  logic                gfx_valid,
  output logic                gfx_ready,
  output fade_pkg::channel_t  vga_red,
  output fade_pkg::channel_t  vga_grn,
  output fade_pkg::channel_t  vga_blu,
  output logic                vga_hsync,
  output logic                vga_vsync
);

  // scan side
  logic               rd_en;
  fade_pkg::fb_addr_t rd_addr;
  fade_pkg::fb_word_t rd_word;
  logic               hsync;
  logic               vsync;
  logic               visible;

  // fade write-back path
  logic               wb_push;
  fade_pkg::fb_addr_t wb_addr;
  fade_pkg::fb_word_t wb_word;
  logic               q_empty;
  logic               q_pop;
  fade_pkg::fb_addr_t q_addr;
  fade_pkg::fb_word_t q_word;

  // merged write port
  logic               wr_en;
  fade_pkg::fb_addr_t wr_addr;
  fade_pkg::fb_word_t wr_word;

  scan_timing u_scan_timing (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .hsync   (hsync),
    .vsync   (vsync),
    .visible (visible)
  );

  fb_memory u_fb_memory (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_word (rd_word),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_word (wr_word)
  );

  fade_stage u_fade_stage (
    .clk        (clk),
    .rst        (rst),
    .rd_word    (rd_word),
    .addr_in    (rd_addr),
    .hsync_in   (hsync),
    .vsync_in   (vsync),
    .visible_in (visible),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .wb_push    (wb_push),
    .wb_addr    (wb_addr),
    .wb_word    (wb_word)
  );

  fade_queue u_fade_queue (
    .clk       (clk),
    .rst       (rst),
    .push      (wb_push),
    .push_addr (wb_addr),
    .push_word (wb_word),
    .pop       (q_pop),
    .empty     (q_empty),
    .pop_addr  (q_addr),
    .pop_word  (q_word)
  );

  fb_write_arbiter u_fb_write_arbiter (
    .clk       (clk),
    .rst       (rst),
    .q_empty   (q_empty),
    .q_addr    (q_addr),
    .q_word    (q_word),
    .q_pop     (q_pop),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_word   (wr_word)
  );

endmodule

`default_nettype wire

/* tb/fade_display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fade_display_checker (
  input logic clk,
  input logic rst,
  input logic push,
  input logic pop,
  input logic full,
  input logic empty,
  input logic ready,
  input logic wr_en
);

  // write-backs must never be dropped or invented
  no_push_when_full: assert property (@(posedge clk) disable iff (rst) full |-> !push)
    else $error("fade queue pushed while full");

  no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("fade queue popped while empty");

  // the client only gets the write port when no write-back waits
  ready_only_when_idle: assert property (@(posedge clk) disable iff (rst) !empty |-> !ready)
    else $error("client ready while write-backs are pending");

  write_idle_after_reset: assert property (@(posedge clk) rst |=> !wr_en)
    else $error("framebuffer write right after reset");

endmodule

bind fade_queue fade_display_checker u_queue_checker (
  .clk   (clk),
  .rst   (rst),
  .push  (push),
  .pop   (pop),
  .full  (full),
  .empty (empty),
  .ready (1'b0),
  .wr_en (1'b0)
);

bind fb_write_arbiter fade_display_checker u_arbiter_checker (
  .clk   (clk),
  .rst   (rst),
  .push  (1'b0),
  .pop   (q_pop),
  .full  (1'b0),
  .empty (q_empty),
  .ready (gfx_ready),
  .wr_en (wr_en)
);

`default_nettype wire

/* tb/fade_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fade_display_tb;

  localparam int clk_period  = 4;
  localparam int frame_len   = fade_pkg::h_whole_line * fade_pkg::v_whole_frame;
  localparam int frame_count = 29;

  // sync windows taken from the raster geometry
  localparam int hs_start = fade_pkg::h_visible + fade_pkg::h_front_porch;
  localparam int hs_end   = hs_start + fade_pkg::h_sync_pulse;
  localparam int vs_start = fade_pkg::v_visible + fade_pkg::v_front_porch;
  localparam int vs_end   = vs_start + fade_pkg::v_sync_pulse;

  localparam int mode_idle = 0;
  localparam int mode_draw = 1;
  localparam int mode_hold = 2;

  logic               clk;
  logic               rst;
  fade_pkg::x_t       gfx_x;
  fade_pkg::y_t       gfx_y;
  fade_pkg::pixel_t   gfx_color;
  logic               gfx_valid;
  logic               gfx_ready;
  fade_pkg::channel_t vga_red;
  fade_pkg::channel_t vga_grn;
  fade_pkg::channel_t vga_blu;
  logic               vga_hsync;
  logic               vga_vsync;

  // reference framebuffer and raster position
  fade_pkg::fb_word_t fb_model [fade_pkg::fb_depth];
  int                 mh;
  int                 mv;
  // expected {hsync, vsync, color} for each of the two pipeline stages
  logic [13:0]        exp_pipe [2];
  // write-backs started by the last three scanned pixels, newest in bit 0
  logic [2:0]         wb_pending;
  logic [31:0]        lfsr;
  logic [31:0]        replay_seed;
  logic               drove_valid;
  logic               saw_ready;
  int                 budget;
  int                 draws;
  int                 stalls;
  string              test_name;

  fade_display_top UUT (
    .clk       (clk),
    .rst       (rst),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] next_random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what,
               expected, actual);
      $display("Done: errors found");
      $fatal(1, "mismatch in %s", test_name);
    end
  endtask

  // the row being scanned and the next one would race a draw against the read
  function automatic logic row_is_busy(input int y);
    return (y == mv) || (y == (mv + 1) % fade_pkg::v_whole_frame);
  endfunction

  // a write-back sits in the queue three cycles after its pixel is scanned
  task automatic verify_client_ready;
    if (wb_pending[2]) begin
      check_equal("ready with write-back queued", 32'(0), 32'(gfx_ready));
    end else if (mv >= fade_pkg::v_visible) begin
      check_equal("ready in blanking", 32'(1), 32'(gfx_ready));
    end
  endtask

  task automatic apply_accepted_draw;
    int addr;
    if (drove_valid && saw_ready) begin
      addr           = int'(gfx_y) * fade_pkg::h_visible + int'(gfx_x);
      fb_model[addr] = {fade_pkg::age_t'(fade_pkg::initial_age), gfx_color};
      draws++;
    end else if (drove_valid) begin
      stalls++;
    end
  endtask

  // predict the output for the current position and age the pixel once
  task automatic model_scan;
    fade_pkg::age_t   age;
    fade_pkg::pixel_t color;
    fade_pkg::pixel_t shown;
    int               addr;
    logic             hs;
    logic             vs;
    shown      = '0;
    wb_pending = {wb_pending[1:0], 1'b0};
    if (mh < fade_pkg::h_visible && mv < fade_pkg::v_visible) begin
      addr  = mv * fade_pkg::h_visible + mh;
      age   = fb_model[addr][15:12];
      color = fb_model[addr][11:0];
      shown = color;
      if (age != '0 && color != '0) begin
        wb_pending[0] = 1'b1;
        age = age - 4'd1;
        if (age == '0) begin
          color = '0;
        end else if (age == fade_pkg::age_t'(fade_pkg::dim_age)) begin
          color = {1'b0, color[11:9], 1'b0, color[7:5], 1'b0, color[3:1]};
        end
        fb_model[addr] = {age, color};
      end
    end
    hs          = !(mh >= hs_start && mh < hs_end);
    vs          = !(mv >= vs_start && mv < vs_end);
    exp_pipe[1] = exp_pipe[0];
    exp_pipe[0] = {hs, vs, shown};
  endtask

  task automatic drive_inputs(input int mode);
    int   x;
    int   y;
    logic chance;
    logic want;
    if (mh == 0 && mv == 0) begin
      budget = 6;
    end
    x      = int'(next_random_bits(4));
    y      = int'(next_random_bits(4)) % fade_pkg::v_visible;
    chance = (next_random_bits(2) == 0);
    want   = 1'b0;
    if (mode == mode_draw) begin
      // sparse draws in vertical blanking while the write port is free
      want = (mv >= fade_pkg::v_visible) && gfx_ready && (budget > 0) && chance &&
             !row_is_busy(y);
    end else if (mode == mode_hold) begin
      want = (mv < fade_pkg::v_visible);
      if (row_is_busy(y)) begin
        y = (y + 2) % fade_pkg::v_visible;
      end
    end
    if (want && mode == mode_draw) begin
      budget--;
    end
    gfx_x       = fade_pkg::x_t'(x);
    gfx_y       = fade_pkg::y_t'(y);
    gfx_color   = fade_pkg::pixel_t'(next_random_bits(12));
    gfx_valid   = want;
    drove_valid = want;
    saw_ready   = gfx_ready;
  endtask

  // one step per falling edge
  // outputs lag the model position by two cycles
  task automatic run_frames(input string name, input int frames, input int mode);
    test_name = name;
    repeat (frames * frame_len) begin
      check_equal("sync and color", 32'(exp_pipe[1]),
                  32'({vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu}));
      verify_client_ready();
      apply_accepted_draw();
      model_scan();
      drive_inputs(mode);
      if (mh == fade_pkg::h_whole_line - 1) begin
        mh = 0;
        mv = (mv + 1) % fade_pkg::v_whole_frame;
      end else begin
        mh++;
      end
      @(negedge clk);
    end
  endtask

  initial begin
    #((frame_count * frame_len + 200) * clk_period);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  initial begin
    rst         = 1'b1;
    gfx_x       = '0;
    gfx_y       = '0;
    gfx_color   = '0;
    gfx_valid   = 1'b0;
    lfsr        = 32'h5262_61ac;
    replay_seed = '0;
    mh          = 0;
    mv          = 0;
    drove_valid = 1'b0;
    saw_ready   = 1'b0;
    budget      = 0;
    draws       = 0;
    stalls      = 0;
    wb_pending  = '0;
    exp_pipe[0] = {1'b1, 1'b1, 12'h000};
    exp_pipe[1] = {1'b1, 1'b1, 12'h000};
    for (int i = 0; i < fade_pkg::fb_depth; i++) begin
      fb_model[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    run_frames("blank screen", 1, mode_idle);
    run_frames("draw in blanking", 3, mode_draw);
    run_frames("fade out", 6, mode_idle);
    // same lfsr state replays the same positions for the redraw
    replay_seed = lfsr;
    run_frames("draw again", 1, mode_draw);
    run_frames("partial fade", 2, mode_idle);
    lfsr = replay_seed;
    run_frames("redraw", 1, mode_draw);
    run_frames("fade after redraw", 6, mode_idle);
    draws  = 0;
    stalls = 0;
    run_frames("back-pressure", 3, mode_hold);
    check_equal("draws accepted", 32'(1), 32'(draws > 0));
    check_equal("stalled cycles", 32'(1), 32'(stalls > 0));
    run_frames("fade after back-pressure", 6, mode_idle);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/fade_pkg.sv
rtl/scan_timing.sv
rtl/fb_memory.sv
rtl/fade_stage.sv
rtl/fade_queue.sv
rtl/fb_write_arbiter.sv
rtl/fade_display_top.sv
tb/fade_display_checker.sv
tb/fade_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module fade_display_tb -f sources.f \
  -o fade_display_sim \
  && ./obj_dir/fade_display_sim > sim.log 2>&1
grep -q "^Done: no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
